/* sim.f */
+incdir+include
hdl/core_pkg.sv
hdl/pipe_ctrl.sv
hdl/if_id_pipe.sv
hdl/inst_decoder.sv
hdl/id_ex_pipe.sv
hdl/id_stage.sv
tb/id_stage_assertions.sv
tb/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the id_stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module id_stage_tb \
    --Mdir obj_dir -o id_stage_sim

status=0
./obj_dir/id_stage_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb/id_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module id_stage_tb;

    import core_pkg::*;

    localparam int N_TESTS         = 7;
    localparam int CYCLES_PER_TEST = 450;  // longest test with margin

    // one id_ex slot as seen by the model
    typedef struct packed {
        logic [31:0] addr;
        logic        reg_we;
        logic [4:0]  waddr;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic        csr_we;
        logic [31:0] cw;
        logic [31:0] cr;
        logic [31:0] imm;
        dec_info_t   info;
    } ex_t;

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        jump_i;
    logic        ex_busy_i;
    logic        fetch_hold_o;
    logic [31:0] inst_addr_o;
    logic        reg_we_o;
    logic [4:0]  reg_waddr_o;
    logic [4:0]  reg1_raddr_o;
    logic [4:0]  reg2_raddr_o;
    logic        csr_we_o;
    logic [31:0] csr_waddr_o;
    logic [31:0] csr_raddr_o;
    logic [31:0] dec_imm_o;
    dec_info_t   dec_info_bus_o;

    logic [31:0] rng_state = 32'hfcbddf89;
    logic [31:0] stim_q[$];  // queued fetch words (random once empty)
    logic [31:0] pc;
    logic [31:0] m_if_inst;  // model of if_id
    logic [31:0] m_if_addr;
    ex_t         m_ex;       // model of id_ex
    logic        held_prev;  // fetch must repeat its word
    logic        fetch_held; // dut fetch hold in the last cycle
    string       cur_test;
    int          errors;
    int          test_err0;
    int          n_pass;
    int          n_fail;

    id_stage dut (
        .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .inst_addr_i(inst_addr_i),
        .jump_i(jump_i), .ex_busy_i(ex_busy_i), .fetch_hold_o(fetch_hold_o),
        .inst_addr_o(inst_addr_o), .reg_we_o(reg_we_o), .reg_waddr_o(reg_waddr_o),
        .reg1_raddr_o(reg1_raddr_o), .reg2_raddr_o(reg2_raddr_o), .csr_we_o(csr_we_o),
        .csr_waddr_o(csr_waddr_o), .csr_raddr_o(csr_raddr_o), .dec_imm_o(dec_imm_o),
        .dec_info_bus_o(dec_info_bus_o)
    );

    bind id_stage id_stage_assertions u_assertions (
        .clk(clk), .reset_i(reset_i), .jump_i(jump_i), .ex_busy_i(ex_busy_i),
        .fetch_hold_i(fetch_hold_o), .reg_we_i(reg_we_o), .csr_we_i(csr_we_o),
        .outs_i({inst_addr_o, reg_we_o, reg_waddr_o, reg1_raddr_o, reg2_raddr_o,
                 csr_we_o, csr_waddr_o, csr_raddr_o, dec_imm_o, dec_info_bus_o})
    );

    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // legal rv32i or zicsr word of class cls, any class when negative
    function automatic logic [31:0] gen_word(input int cls);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = next_rand();
        rd  = r[11:7];
        rs1 = r[19:15];
        rs2 = r[24:20];
        f3  = r[14:12];
        if (cls < 0) cls = int'(next_rand() % 32'd10);
        case (cls)
            0: return {r[31:12], rd, `OPC_LUI};
            1: return {r[31:12], rd, `OPC_AUIPC};
            2: return {r[31:12], rd, `OPC_JAL};
            3: return {r[31:20], rs1, 3'b000, rd, `OPC_JALR};
            4: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // skip reserved branch codes
                return {r[31:25], rs2, rs1, f3, r[11:7], `OPC_BRANCH};
            end
            5: begin
                if (f3 == 3'b011) f3 = 3'b000;
                if (f3[2:1] == 2'b11) f3[1] = 1'b0;  // lb lh lw lbu lhu
                return {r[31:20], rs1, f3, rd, `OPC_LOAD};
            end
            6: return {r[31:25], rs2, rs1, 3'(r[1:0] % 2'd3), r[11:7], `OPC_STORE};
            7: begin
                if (f3[1:0] != 2'b01) return {r[31:20], rs1, f3, rd, `OPC_OP_IMM};
                f7 = (f3[2] && r[0]) ? 7'h20 : 7'h00;  // srai only
                return {f7, rs2, rs1, f3, rd, `OPC_OP_IMM};
            end
            8: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, `OPC_OP};
            end
            default: begin
                if (f3[1:0] == 2'b00) f3[0] = 1'b1;
                rs1 = rs1 & {5{r[2]}};  // zero rs1 half the time
                return {r[31:20], rs1, f3, rd, `OPC_SYSTEM};
            end
        endcase
    endfunction

    // reference decode from the isa encodings
    function automatic ex_t model_decode(input logic [31:0] w, input logic [31:0] a);
        ex_t        d;
        logic       wr;
        logic [2:0] f3;
        d            = '0;
        d.addr       = a;
        d.info.grp   = GRP_ALU;
        d.info.use_imm = 1'b1;  // nop is addi
        wr           = 1'b0;
        f3           = w[14:12];
        case (w[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                wr = 1'b1;
                d.imm = {w[31:12], 12'h000};
                d.info.op = (w[6:0] == `OPC_LUI) ? 4'b1000 : 4'b1001;
            end
            `OPC_JAL: begin
                wr = 1'b1;
                d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                d.info.grp = GRP_BJP;
                d.info.op = 4'b1010;
            end
            `OPC_JALR: begin
                wr = 1'b1;
                d.r1 = w[19:15];
                d.imm = {{20{w[31]}}, w[31:20]};
                d.info.grp = GRP_BJP;
                d.info.op = 4'b1011;
            end
            `OPC_BRANCH: begin
                d.r1 = w[19:15];
                d.r2 = w[24:20];
                d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                d.info = '{GRP_BJP, {1'b0, f3}, 1'b0, 1'b0};
            end
            `OPC_LOAD: begin
                wr = 1'b1;
                d.r1 = w[19:15];
                d.imm = {{20{w[31]}}, w[31:20]};
                d.info = '{GRP_LSU, {1'b0, f3}, 1'b1, 1'b1};
            end
            `OPC_STORE: begin
                d.r1 = w[19:15];
                d.r2 = w[24:20];
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                d.info = '{GRP_LSU, {1'b0, f3}, 1'b1, 1'b0};
            end
            `OPC_OP_IMM: begin
                wr = 1'b1;
                d.r1 = w[19:15];
                if (f3[1:0] == 2'b01) begin  // shifts carry shamt
                    d.imm = {27'd0, w[24:20]};
                    d.info.op = {w[30], f3};
                end else begin
                    d.imm = {{20{w[31]}}, w[31:20]};
                    d.info.op = {1'b0, f3};
                end
            end
            `OPC_OP: begin
                wr = 1'b1;
                d.r1 = w[19:15];
                d.r2 = w[24:20];
                d.info = '{GRP_ALU, {w[30], f3}, 1'b0, 1'b0};
            end
            `OPC_SYSTEM: begin
                wr = 1'b1;
                d.r1 = f3[2] ? 5'd0 : w[19:15];
                d.imm = f3[2] ? {27'd0, w[19:15]} : 32'd0;  // zimm
                d.csr_we = !(f3[1] && w[19:15] == 5'd0);
                d.cw = {20'd0, w[31:20]};
                d.cr = {20'd0, w[31:20]};
                d.info = '{GRP_CSR, {1'b0, f3}, f3[2], 1'b0};
            end
            default: ;
        endcase
        d.reg_we = wr && (w[11:7] != 5'd0);
        d.waddr  = wr ? w[11:7] : 5'd0;
        return d;
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s.%s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string what, input logic [4:0] exp, input logic [4:0] act);
        if (exp !== act) begin
            $display("FAILED %s.%s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s.%s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_info(input string what, input dec_info_t exp, input dec_info_t act);
        if (exp !== act) begin
            $display("FAILED %s.%s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_ex(input ex_t e);
        check_word("inst_addr", e.addr, inst_addr_o);
        check_bit("reg_we", e.reg_we, reg_we_o);
        check_reg("reg_waddr", e.waddr, reg_waddr_o);
        check_reg("reg1_raddr", e.r1, reg1_raddr_o);
        check_reg("reg2_raddr", e.r2, reg2_raddr_o);
        check_bit("csr_we", e.csr_we, csr_we_o);
        check_word("csr_waddr", e.cw, csr_waddr_o);
        check_word("csr_raddr", e.cr, csr_raddr_o);
        check_word("dec_imm", e.imm, dec_imm_o);
        check_info("dec_info", e.info, dec_info_bus_o);
    endtask

    // one clock of drive, fetch hold check, model step and id_ex check
    task automatic run_cycle(input logic jmp, input logic busy);
        ex_t   d;
        hold_e h;
        if (!held_prev) begin
            inst_i = (stim_q.size() > 0) ? stim_q.pop_front() : gen_word(-1);
            inst_addr_i = pc;
            pc = pc + 32'd4;
        end
        jump_i    = jmp;
        ex_busy_i = busy;
        d = model_decode(m_if_inst, m_if_addr);
        if (jmp) h = HOLD_FLUSH;
        else if (busy) h = HOLD_ID;
        else if (m_ex.info.is_load && m_ex.waddr != 5'd0 &&
                 ((d.r1 != 5'd0 && d.r1 == m_ex.waddr) ||
                  (d.r2 != 5'd0 && d.r2 == m_ex.waddr))) h = HOLD_IF;
        else h = HOLD_NONE;
        #1;
        check_bit("fetch_hold", (h == HOLD_IF || h == HOLD_ID), fetch_hold_o);
        fetch_held = fetch_hold_o;
        @(posedge clk);
        case (h)
            HOLD_FLUSH: begin
                m_if_inst = `INST_NOP;
                m_if_addr = 32'd0;
                m_ex = '0;
            end
            HOLD_IF: m_ex = '0;  // bubble while decode word stays
            HOLD_ID: ;
            default: begin
                m_ex = d;
                m_if_inst = inst_i;
                m_if_addr = inst_addr_i;
            end
        endcase
        held_prev = (h == HOLD_IF || h == HOLD_ID);
        #1;
        compare_ex(m_ex);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("test %s: passed", cur_test);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
            n_fail++;
        end
    endtask

    task automatic drain_nops(input int n);
        repeat (n) stim_q.push_back(`INST_NOP);
        while (stim_q.size() > 0) run_cycle(1'b0, 1'b0);
    endtask

    // counts dut fetch stalls over a load to rd and its reader
    task automatic load_then(input logic [4:0] rd, input logic [31:0] reader, output int stalls);
        drain_nops(3);
        stalls = 0;
        stim_q.push_back({12'h010, 5'd2, 3'b010, rd, `OPC_LOAD});  // lw rd, 16(x2)
        stim_q.push_back(reader);
        repeat (4) stim_q.push_back(`INST_NOP);
        while (stim_q.size() > 0) begin
            run_cycle(1'b0, 1'b0);
            if (fetch_held) stalls++;
        end
    endtask

    initial begin
        int          n;
        int          stalls;
        logic [4:0]  rd;
        clk = 1'b0;
        reset_i = 1'b1;
        inst_i = `INST_NOP;
        inst_addr_i = 32'd0;
        jump_i = 1'b0;
        ex_busy_i = 1'b0;
        pc = 32'h0000_1000;
        m_if_inst = `INST_NOP;
        m_if_addr = 32'd0;
        m_ex = '0;
        held_prev = 1'b0;
        fetch_held = 1'b0;
        errors = 0;
        n_pass = 0;
        n_fail = 0;

        begin_test("reset_values");
        repeat (16) begin
            @(posedge clk);
            #1;
            check_bit("reg_we", 1'b0, reg_we_o);
            check_bit("csr_we", 1'b0, csr_we_o);
            check_bit("fetch_hold", 1'b0, fetch_hold_o);
        end
        reset_i = 1'b0;  // released 1 ns after the 16th edge
        #1;
        check_bit("fetch_hold", 1'b0, fetch_hold_o);
        compare_ex(m_ex);
        end_test();

        begin_test("free_flow");
        repeat (400) run_cycle(1'b0, 1'b0);
        end_test();

        begin_test("csr_decode");
        repeat (100) stim_q.push_back(gen_word(9));
        while (stim_q.size() > 0) run_cycle(1'b0, 1'b0);
        end_test();

        begin_test("flush");
        repeat (20) begin
            run_cycle(1'b0, 1'b0);
            run_cycle(1'b1, 1'b0);
            check_bit("bubble_reg_we", 1'b0, reg_we_o);
            check_info("bubble_info", '0, dec_info_bus_o);
            check_word("bubble_imm", 32'd0, dec_imm_o);
            run_cycle(1'b0, 1'b0);  // nop left in if_id now decodes
            compare_ex(model_decode(`INST_NOP, 32'd0));
        end
        end_test();

        begin_test("ex_busy");
        repeat (20) begin
            n = 1 + int'(next_rand() % 32'd5);
            repeat (n) run_cycle(1'b0, 1'b1);
            repeat (3) run_cycle(1'b0, 1'b0);
        end
        end_test();

        begin_test("load_use");
        repeat (10) begin
            rd = 5'd1 + 5'(next_rand() % 32'd31);
            load_then(rd, {7'h00, 5'd3, rd, 3'b000, 5'd7, `OPC_OP}, stalls);
            check_word("stalls_dep", 32'd1, stalls);
            load_then(rd, {7'h00, rd ^ 5'd1, 5'd0, 3'b000, 5'd7, `OPC_OP}, stalls);
            check_word("stalls_indep", 32'd0, stalls);
        end
        end_test();

        begin_test("mixed_events");
        repeat (300) run_cycle(next_rand() % 32'd12 == 0, next_rand() % 32'd12 == 0);
        end_test();

        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST + 100) @(posedge clk);
        $display("run timed out before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/id_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions (
    input wire         clk,
    input wire         reset_i,
    input wire         jump_i,
    input wire         ex_busy_i,
    input wire         fetch_hold_i,
    input wire         reg_we_i,
    input wire         csr_we_i,
    input wire [152:0] outs_i        // every id_ex output, concatenated
);

    // a jump leaves a bubble, so nothing writes back next cycle
    jump_kills_we: assert property (
        @(posedge clk) disable iff (reset_i)
        jump_i |=> (!reg_we_i && !csr_we_i)
    ) else $error("write enable set after a jump");

    // busy execute stalls fetch unless a jump wins
    busy_holds_fetch: assert property (
        @(posedge clk) disable iff (reset_i)
        (ex_busy_i && !jump_i) |-> fetch_hold_i
    ) else $error("fetch not held while execute busy");

    busy_freezes_outs: assert property (
        @(posedge clk) disable iff (reset_i)
        (ex_busy_i && !jump_i) |=> $stable(outs_i)
    ) else $error("id_ex outputs changed across a busy cycle");

    no_x_on_outs: assert property (
        @(posedge clk) !reset_i |-> !$isunknown({outs_i, fetch_hold_i})
    ) else $error("unknown value on an output");

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module id_stage (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire [`INST_WIDTH-1:0]        inst_i,
    input  wire [`INST_ADDR_WIDTH-1:0]   inst_addr_i,
    input  wire                          jump_i,
    input  wire                          ex_busy_i,
    output logic                         fetch_hold_o,  // fetch repeats its word
    output logic [`INST_ADDR_WIDTH-1:0]  inst_addr_o,
    output logic                         reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg_waddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg1_raddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg2_raddr_o,
    output logic                         csr_we_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_waddr_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_raddr_o,
    output logic [`INST_WIDTH-1:0]       dec_imm_o,
    output core_pkg::dec_info_t          dec_info_bus_o
);

    import core_pkg::*;

    hold_e                       hold_level;
    logic [`INST_WIDTH-1:0]      id_inst;       // word in decode
    logic [`INST_ADDR_WIDTH-1:0] id_inst_addr;
    logic                        reg_we;
    logic [`REG_ADDR_WIDTH-1:0]  reg_waddr;
    logic [`REG_ADDR_WIDTH-1:0]  reg1_raddr;
    logic [`REG_ADDR_WIDTH-1:0]  reg2_raddr;
    logic                        csr_we;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr;
    logic [`INST_WIDTH-1:0]      dec_imm;
    dec_info_t                   dec_info;

    // hazard check uses decode reads against the registered ex write
    pipe_ctrl u_pipe_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .jump_i          (jump_i),
        .ex_busy_i       (ex_busy_i),
        .id_reg1_raddr_i (reg1_raddr),
        .id_reg2_raddr_i (reg2_raddr),
        .ex_reg_waddr_i  (reg_waddr_o),
        .ex_is_load_i    (dec_info_bus_o.is_load),
        .hold_level_o    (hold_level),
        .fetch_hold_o    (fetch_hold_o)
    );

    if_id_pipe u_if_id_pipe (
        .clk          (clk),
        .reset_i      (reset_i),
        .hold_level_i (hold_level),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .inst_o       (id_inst),
        .inst_addr_o  (id_inst_addr)
    );

    inst_decoder u_inst_decoder (
        .inst_i       (id_inst),
        .reg_we_o     (reg_we),
        .reg_waddr_o  (reg_waddr),
        .reg1_raddr_o (reg1_raddr),
        .reg2_raddr_o (reg2_raddr),
        .csr_we_o     (csr_we),
        .csr_waddr_o  (csr_waddr),
        .csr_raddr_o  (csr_raddr),
        .dec_imm_o    (dec_imm),
        .dec_info_o   (dec_info)
    );

    id_ex_pipe u_id_ex_pipe (
        .clk            (clk),
        .reset_i        (reset_i),
        .hold_level_i   (hold_level),
        .inst_addr_i    (id_inst_addr),
        .reg_we_i       (reg_we),
        .reg_waddr_i    (reg_waddr),
        .reg1_raddr_i   (reg1_raddr),
        .reg2_raddr_i   (reg2_raddr),
        .csr_we_i       (csr_we),
        .csr_waddr_i    (csr_waddr),
        .csr_raddr_i    (csr_raddr),
        .dec_imm_i      (dec_imm),
        .dec_info_bus_i (dec_info),        // packed struct onto flat bus
        .inst_addr_o    (inst_addr_o),
        .reg_we_o       (reg_we_o),
        .reg_waddr_o    (reg_waddr_o),
        .reg1_raddr_o   (reg1_raddr_o),
        .reg2_raddr_o   (reg2_raddr_o),
        .csr_we_o       (csr_we_o),
        .csr_waddr_o    (csr_waddr_o),
        .csr_raddr_o    (csr_raddr_o),
        .dec_imm_o      (dec_imm_o),
        .dec_info_bus_o (dec_info_bus_o)
    );

endmodule

`default_nettype wire

/* hdl/id_ex_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module id_ex_pipe (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire core_pkg::hold_e         hold_level_i,
    input  wire [`INST_ADDR_WIDTH-1:0]   inst_addr_i,
    input  wire                          reg_we_i,
    input  wire [`REG_ADDR_WIDTH-1:0]    reg_waddr_i,
    input  wire [`REG_ADDR_WIDTH-1:0]    reg1_raddr_i,     // address, data read in ex
    input  wire [`REG_ADDR_WIDTH-1:0]    reg2_raddr_i,
    input  wire                          csr_we_i,
    input  wire [`BUS_ADDR_WIDTH-1:0]    csr_waddr_i,
    input  wire [`BUS_ADDR_WIDTH-1:0]    csr_raddr_i,
    input  wire [`INST_WIDTH-1:0]        dec_imm_i,
    input  wire [`DECINFO_WIDTH-1:0]     dec_info_bus_i,
    output logic [`INST_ADDR_WIDTH-1:0]  inst_addr_o,
    output logic                         reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg_waddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg1_raddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg2_raddr_o,
    output logic                         csr_we_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_waddr_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_raddr_o,
    output logic [`INST_WIDTH-1:0]       dec_imm_o,
    output logic [`DECINFO_WIDTH-1:0]    dec_info_bus_o
);

    import core_pkg::*;

    logic clear_en;  // flush or load-use bubble
    logic load_en;

    assign clear_en = (hold_level_i == HOLD_FLUSH) || (hold_level_i == HOLD_IF);
    assign load_en  = (hold_level_i == HOLD_NONE);  // HOLD_ID falls through and keeps

    always_ff @(posedge clk) begin
        if (reset_i || clear_en) begin
            inst_addr_o    <= `ZERO_WORD;
            reg_we_o       <= 1'b0;  // bubble never writes back
            reg_waddr_o    <= '0;
            reg1_raddr_o   <= '0;
            reg2_raddr_o   <= '0;
            csr_we_o       <= 1'b0;
            csr_waddr_o    <= `ZERO_WORD;
            csr_raddr_o    <= `ZERO_WORD;
            dec_imm_o      <= `ZERO_WORD;
            dec_info_bus_o <= '0;    // alu add, not a load
        end else if (load_en) begin
            inst_addr_o    <= inst_addr_i;
            reg_we_o       <= reg_we_i;
            reg_waddr_o    <= reg_waddr_i;
            reg1_raddr_o   <= reg1_raddr_i;
            reg2_raddr_o   <= reg2_raddr_i;
            csr_we_o       <= csr_we_i;
            csr_waddr_o    <= csr_waddr_i;
            csr_raddr_o    <= csr_raddr_i;
            dec_imm_o      <= dec_imm_i;
            dec_info_bus_o <= dec_info_bus_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module inst_decoder (
    input  wire [`INST_WIDTH-1:0]        inst_i,
    output logic                         reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]   reg_waddr_o,   // 0 when rd unused
    output logic [`REG_ADDR_WIDTH-1:0]   reg1_raddr_o,  // 0 when rs1 unused
    output logic [`REG_ADDR_WIDTH-1:0]   reg2_raddr_o,  // 0 when rs2 unused
    output logic                         csr_we_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_waddr_o,
    output logic [`BUS_ADDR_WIDTH-1:0]   csr_raddr_o,
    output logic [`INST_WIDTH-1:0]       dec_imm_o,
    output core_pkg::dec_info_t          dec_info_o
);

    import core_pkg::*;

    logic [6:0]                 opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`INST_WIDTH-1:0]     imm_i;
    logic [`INST_WIDTH-1:0]     imm_s;
    logic [`INST_WIDTH-1:0]     imm_b;
    logic [`INST_WIDTH-1:0]     imm_u;
    logic [`INST_WIDTH-1:0]     imm_j;
    logic                       shift_imm;
    logic                       op_imm_ok;
    logic                       op_ok;
    logic                       rd_wr;  // format writes rd

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    // sign-extended immediates per format
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign shift_imm = (funct3[1:0] == 2'b01);  // slli, srli, srai
    assign op_imm_ok = !shift_imm || (funct7 == 7'h00) || (funct3[2] && funct7 == 7'h20);
    assign op_ok     = (funct7 == 7'h00)
                     || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)); // sub, sra

    always_comb begin
        // defaults are the decode of addi x0, x0, 0
        rd_wr        = 1'b0;
        reg1_raddr_o = '0;
        reg2_raddr_o = '0;
        csr_we_o     = 1'b0;
        csr_waddr_o  = '0;
        csr_raddr_o  = '0;
        dec_imm_o    = `ZERO_WORD;
        dec_info_o   = '{grp: GRP_ALU, op: 4'b0000, use_imm: 1'b1, is_load: 1'b0};
        case (opcode)
            `OPC_LUI: begin
                rd_wr      = 1'b1;
                dec_imm_o  = imm_u;
                dec_info_o = '{GRP_ALU, 4'b1000, 1'b1, 1'b0};
            end
            `OPC_AUIPC: begin
                rd_wr      = 1'b1;
                dec_imm_o  = imm_u;
                dec_info_o = '{GRP_ALU, 4'b1001, 1'b1, 1'b0};
            end
            `OPC_JAL: begin
                rd_wr      = 1'b1;
                dec_imm_o  = imm_j;
                dec_info_o = '{GRP_BJP, 4'b1010, 1'b1, 1'b0};
            end
            `OPC_JALR: if (funct3 == 3'b000) begin
                rd_wr        = 1'b1;
                reg1_raddr_o = rs1;
                dec_imm_o    = imm_i;
                dec_info_o   = '{GRP_BJP, 4'b1011, 1'b1, 1'b0};
            end
            `OPC_BRANCH: if (funct3[2:1] != 2'b01) begin  // 010/011 reserved
                reg1_raddr_o = rs1;
                reg2_raddr_o = rs2;
                dec_imm_o    = imm_b;   // target offset, operands stay registers
                dec_info_o   = '{GRP_BJP, {1'b0, funct3}, 1'b0, 1'b0};
            end
            `OPC_LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                rd_wr        = 1'b1;
                reg1_raddr_o = rs1;
                dec_imm_o    = imm_i;
                dec_info_o   = '{GRP_LSU, {1'b0, funct3}, 1'b1, 1'b1};
            end
            `OPC_STORE: if (funct3 < 3'b011) begin  // sb, sh, sw
                reg1_raddr_o = rs1;
                reg2_raddr_o = rs2;
                dec_imm_o    = imm_s;
                dec_info_o   = '{GRP_LSU, {1'b0, funct3}, 1'b1, 1'b0};
            end
            `OPC_OP_IMM: if (op_imm_ok) begin
                rd_wr          = 1'b1;
                reg1_raddr_o   = rs1;
                dec_imm_o      = shift_imm ? {27'b0, inst_i[24:20]} : imm_i;  // shamt only
                dec_info_o.grp = GRP_ALU;
                dec_info_o.op  = shift_imm ? {inst_i[30], funct3} : {1'b0, funct3};
            end
            `OPC_OP: if (op_ok) begin
                rd_wr        = 1'b1;
                reg1_raddr_o = rs1;
                reg2_raddr_o = rs2;
                dec_info_o   = '{GRP_ALU, {inst_i[30], funct3}, 1'b0, 1'b0};
            end
            `OPC_SYSTEM: if (funct3[1:0] != 2'b00) begin  // csr ops only
                rd_wr        = 1'b1;
                reg1_raddr_o = funct3[2] ? '0 : rs1;              // imm forms hold zimm
                dec_imm_o    = funct3[2] ? {27'b0, rs1} : `ZERO_WORD;
                csr_we_o     = !(funct3[1] && rs1 == '0);         // set/clear with 0 only reads
                csr_waddr_o  = {{(`BUS_ADDR_WIDTH-12){1'b0}}, inst_i[31:20]};
                csr_raddr_o  = {{(`BUS_ADDR_WIDTH-12){1'b0}}, inst_i[31:20]};
                dec_info_o   = '{GRP_CSR, {1'b0, funct3}, funct3[2], 1'b0};
            end
            default: begin
                // not rv32i or zicsr, stays a nop
            end
        endcase
        reg_we_o    = rd_wr && (rd != '0);  // x0 is never written
        reg_waddr_o = rd_wr ? rd : '0;
    end

endmodule

`default_nettype wire

/* hdl/if_id_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module if_id_pipe (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire core_pkg::hold_e         hold_level_i,
    input  wire [`INST_WIDTH-1:0]        inst_i,       // fetched word
    input  wire [`INST_ADDR_WIDTH-1:0]   inst_addr_i,  // its pc
    output logic [`INST_WIDTH-1:0]       inst_o,
    output logic [`INST_ADDR_WIDTH-1:0]  inst_addr_o
);

    import core_pkg::*;

    // a flushed or reset slot holds the nop word, which decodes to addi x0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o      <= `INST_NOP;
            inst_addr_o <= `ZERO_WORD;
        end else begin
            case (hold_level_i)
                HOLD_FLUSH: begin
                    inst_o      <= `INST_NOP;   // kill wrong-path word
                    inst_addr_o <= `ZERO_WORD;
                end
                HOLD_IF, HOLD_ID: begin
                    inst_o      <= inst_o;      // stall, keep word
                    inst_addr_o <= inst_addr_o;
                end
                default: begin
                    inst_o      <= inst_i;      // normal advance
                    inst_addr_o <= inst_addr_i;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module pipe_ctrl (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire                        jump_i,           // one-cycle pulse from ex
    input  wire                        ex_busy_i,        // level from ex
    input  wire [`REG_ADDR_WIDTH-1:0]  id_reg1_raddr_i,  // 0 when rs1 unused
    input  wire [`REG_ADDR_WIDTH-1:0]  id_reg2_raddr_i,  // 0 when rs2 unused
    input  wire [`REG_ADDR_WIDTH-1:0]  ex_reg_waddr_i,
    input  wire                        ex_is_load_i,
    output core_pkg::hold_e            hold_level_o,
    output logic                       fetch_hold_o
);

    import core_pkg::*;

    logic in_reset_q;  // follows reset by one edge
    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    // keeps the level at none while the pipe registers come out of reset
    always_ff @(posedge clk) begin
        in_reset_q <= reset_i;
    end

    assign rs1_hit = (id_reg1_raddr_i != '0) && (id_reg1_raddr_i == ex_reg_waddr_i);
    assign rs2_hit = (id_reg2_raddr_i != '0) && (id_reg2_raddr_i == ex_reg_waddr_i);

    // load result not ready before the dependent op reaches ex
    assign load_use = ex_is_load_i && (ex_reg_waddr_i != '0) && (rs1_hit || rs2_hit);

    always_comb begin
        if (in_reset_q) begin
            hold_level_o = HOLD_NONE;
        end else if (jump_i) begin
            hold_level_o = HOLD_FLUSH;  // jump beats everything
        end else if (ex_busy_i) begin
            hold_level_o = HOLD_ID;
        end else if (load_use) begin
            hold_level_o = HOLD_IF;     // one bubble
        end else begin
            hold_level_o = HOLD_NONE;
        end
    end

    // fetch repeats its word on either stall level, not on flush
    assign fetch_hold_o = (hold_level_o == HOLD_IF) || (hold_level_o == HOLD_ID);

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    // one level drives both pipe registers
    typedef enum logic [2:0] {
        HOLD_NONE,  // all stages advance
        HOLD_IF,    // load-use, keep if_id and bubble id_ex
        HOLD_ID,    // execute busy, freeze if_id and id_ex
        HOLD_FLUSH  // jump taken, kill both
    } hold_e;

    typedef enum logic [1:0] {
        GRP_ALU,    // reg/imm arithmetic, lui, auipc
        GRP_BJP,    // branches, jal, jalr
        GRP_LSU,    // loads and stores
        GRP_CSR     // zicsr
    } dec_grp_e;

    // op encoding
    //   alu reg and shift forms: {inst[30], funct3}
    //   others: {1'b0, funct3}
    //   lui 1000, auipc 1001 (alu), jal 1010, jalr 1011 (bjp)
    typedef struct packed {
        dec_grp_e   grp;
        logic [3:0] op;
        logic       use_imm;  // second operand is dec_imm
        logic       is_load;  // rd is written from memory
    } dec_info_t;

endpackage

`default_nettype wire

/* include/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths, fixed by the isa
`define INST_WIDTH       32
`define INST_ADDR_WIDTH  32
`define REG_ADDR_WIDTH   5
`define BUS_ADDR_WIDTH   32            // csr address, zero-extended from 12 bits
`define DECINFO_WIDTH    8             // packed size of core_pkg::dec_info_t

`define INST_NOP         32'h0000_0013 // addi x0, x0, 0
`define ZERO_WORD        32'h0000_0000

// rv32i major opcodes
`define OPC_LUI          7'b0110111
`define OPC_AUIPC        7'b0010111
`define OPC_JAL          7'b1101111
`define OPC_JALR         7'b1100111
`define OPC_BRANCH       7'b1100011
`define OPC_LOAD         7'b0000011
`define OPC_STORE        7'b0100011
`define OPC_OP_IMM       7'b0010011
`define OPC_OP           7'b0110011
`define OPC_SYSTEM       7'b1110011    // zicsr lives here

`endif
